// ==== common/ex_pkg.sv ====
package ex_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Data path width
    localparam int unsigned WORD_SIZE = 32;
    // Architectural register count
    localparam int unsigned NUM_REGS  = 32;
    // Register index width
    localparam int unsigned REG_SEL   = $clog2(NUM_REGS);
    // Program counter width
    localparam int unsigned ADDR_SIZE = 10;

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [ADDR_SIZE-1:0] addr_t;
    typedef logic [REG_SEL-1:0]   reg_sel_t;

    // ALU operation codes
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_e;

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////

    // One issued instruction
    typedef struct packed {
        logic     valid;
        addr_t    pc;        // Address after this instruction
        reg_sel_t rs1;
        reg_sel_t rs2;
        reg_sel_t rd;
        word_t    imm;
        alu_op_e  alu_op;
        logic     alu_src;   // Set when imm feeds the ALU
        logic     reg_write;
        logic     branch;
    } issue_t;

    // ID/EX contents, issue fields plus operand reads
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_sel_t rs1;
        reg_sel_t rs2;
        reg_sel_t rd;
        word_t    imm;
        alu_op_e  alu_op;
        logic     alu_src;
        logic     reg_write;
        logic     branch;
        word_t    data1;
        word_t    data2;
    } id_ex_t;

    // EX/MEM, MEM/WB and retire contents
    typedef struct packed {
        logic     valid;
        reg_sel_t rd;
        logic     reg_write;
        word_t    result;
        word_t    write_data;   // Store data, carried only
        logic     branch;
        logic     taken;
        addr_t    branch_target;
    } stage_t;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  ex_pkg::reg_sel_t rs1,
    input  ex_pkg::reg_sel_t rs2,
    output ex_pkg::word_t    data1,
    output ex_pkg::word_t    data2,
    input  logic             we,
    input  ex_pkg::reg_sel_t rd,
    input  ex_pkg::word_t    wdata
);

    // Storage, entry zero never written
    ex_pkg::word_t regs [ex_pkg::NUM_REGS];

    // Write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ex_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Zero register first, then same-cycle write bypass
    assign data1 = (rs1 == '0)             ? '0    :
                   (we && rd == rs1)       ? wdata :
                                             regs[rs1];

    // Same rule for the second port
    assign data2 = (rs2 == '0)             ? '0    :
                   (we && rd == rs2)       ? wdata :
                                             regs[rs2];

endmodule

// ==== design/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit (
    input  ex_pkg::reg_sel_t rs1,
    input  ex_pkg::reg_sel_t rs2,
    input  ex_pkg::stage_t   ex_mem,
    input  ex_pkg::stage_t   mem_wb,
    output ex_pkg::fwd_sel_e sel_forward1,
    output ex_pkg::fwd_sel_e sel_forward2
);

    // Stage holds a live write to this source
    function automatic logic writes_reg(
        ex_pkg::stage_t   stage,
        ex_pkg::reg_sel_t src
    );
        return stage.valid && stage.reg_write &&
               (stage.rd != '0) && (stage.rd == src);
    endfunction

    // MEM is younger, so it wins over WB
    function automatic ex_pkg::fwd_sel_e pick_source(
        ex_pkg::reg_sel_t src,
        ex_pkg::stage_t   mem_stage,
        ex_pkg::stage_t   wb_stage
    );
        if (writes_reg(mem_stage, src)) begin
            return ex_pkg::fwd_mem;
        end
        if (writes_reg(wb_stage, src)) begin
            return ex_pkg::fwd_wb;
        end
        // Nothing in flight, register file value
        return ex_pkg::fwd_reg;
    endfunction

    //////////////////////////////////////////////////
    // Per-source selects
    //////////////////////////////////////////////////

    assign sel_forward1 = pick_source(rs1, ex_mem, mem_wb);
    assign sel_forward2 = pick_source(rs2, ex_mem, mem_wb);

endmodule

// ==== ex_stage/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  ex_pkg::alu_op_e alu_op,
    input  ex_pkg::word_t   arg1,
    input  ex_pkg::word_t   arg2,
    output ex_pkg::word_t   result,
    output logic            zero
);

    // Shift amount from low bits of arg2
    logic [4:0] shamt;

    assign shamt = arg2[4:0];

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            ex_pkg::alu_add: begin
                result = arg1 + arg2;
            end
            ex_pkg::alu_sub: begin
                result = arg1 - arg2;
            end
            ex_pkg::alu_and: begin
                result = arg1 & arg2;
            end
            ex_pkg::alu_or: begin
                result = arg1 | arg2;
            end
            ex_pkg::alu_xor: begin
                result = arg1 ^ arg2;
            end
            ex_pkg::alu_sll: begin
                result = arg1 << shamt;
            end
            // Logical, zero fill
            ex_pkg::alu_srl: begin
                result = arg1 >> shamt;
            end
            // Arithmetic, sign fill
            ex_pkg::alu_sra: begin
                result = ex_pkg::word_t'($signed(arg1) >>> shamt);
            end
            // Signed compare, 0 or 1
            ex_pkg::alu_slt: begin
                result = {{(ex_pkg::WORD_SIZE-1){1'b0}}, $signed(arg1) < $signed(arg2)};
            end
            // Unsigned compare
            ex_pkg::alu_sltu: begin
                result = {{(ex_pkg::WORD_SIZE-1){1'b0}}, arg1 < arg2};
            end
            // Unknown codes
            default: begin
                result = '0;
            end
        endcase
    end

    // Branch-if-equal uses this after sub
    assign zero = (result == '0);

endmodule

// ==== ex_stage/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  ex_pkg::id_ex_t   id_ex,
    input  ex_pkg::word_t    mem_forward,
    input  ex_pkg::word_t    wb_forward,
    input  ex_pkg::fwd_sel_e sel_forward1,
    input  ex_pkg::fwd_sel_e sel_forward2,
    output ex_pkg::stage_t   ex_out
);

    ex_pkg::word_t operand1;     // Forwarded rs1 value
    ex_pkg::word_t operand2;     // Forwarded rs2 value
    ex_pkg::word_t alu_arg2;
    ex_pkg::word_t alu_result;
    ex_pkg::word_t byte_offset;
    logic          alu_zero;

    // Three-way operand choice
    function automatic ex_pkg::word_t pick_operand(
        ex_pkg::fwd_sel_e sel,
        ex_pkg::word_t    reg_value,
        ex_pkg::word_t    mem_value,
        ex_pkg::word_t    wb_value
    );
        case (sel)
            ex_pkg::fwd_mem: return mem_value;
            ex_pkg::fwd_wb:  return wb_value;
            default:         return reg_value;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////

    assign operand1 = pick_operand(sel_forward1, id_ex.data1, mem_forward, wb_forward);
    assign operand2 = pick_operand(sel_forward2, id_ex.data2, mem_forward, wb_forward);

    // Immediate or forwarded rs2
    assign alu_arg2 = id_ex.alu_src ? id_ex.imm : operand2;

    alu alu_i (
        .alu_op (id_ex.alu_op),
        .arg1   (operand1),
        .arg2   (alu_arg2),
        .result (alu_result),
        .zero   (alu_zero)
    );

    //////////////////////////////////////////////////
    // Branch and result
    //////////////////////////////////////////////////

    // Word offset to bytes
    assign byte_offset = id_ex.imm << 2;

    always_comb begin
        ex_out.valid         = id_ex.valid;
        ex_out.rd            = id_ex.rd;
        ex_out.reg_write     = id_ex.reg_write;
        ex_out.result        = alu_result;
        // Store data follows rs2 forwarding
        ex_out.write_data    = operand2;
        ex_out.branch        = id_ex.branch;
        // Equal operands give zero difference
        ex_out.taken         = id_ex.branch && alu_zero;
        // Wraps at pc width
        ex_out.branch_target = id_ex.pc + byte_offset[ex_pkg::ADDR_SIZE-1:0];
    end

endmodule

// ==== design/exec_pipe.sv ====
`timescale 1ns/1ps

module exec_pipe (
    input  logic           clk,
    input  logic           reset,
    input  ex_pkg::issue_t issue,
    output ex_pkg::stage_t retire
);

    ex_pkg::id_ex_t   id_ex;
    ex_pkg::stage_t   ex_out;
    ex_pkg::stage_t   ex_mem;
    ex_pkg::stage_t   mem_wb;
    ex_pkg::word_t    rf_data1;
    ex_pkg::word_t    rf_data2;
    ex_pkg::fwd_sel_e sel_forward1;
    ex_pkg::fwd_sel_e sel_forward2;
    logic             rf_we;

    //////////////////////////////////////////////////
    // Register file and write-back
    //////////////////////////////////////////////////

    // Only live writers from MEM/WB
    assign rf_we = mem_wb.valid && mem_wb.reg_write;

    reg_file reg_file_i (
        .clk   (clk),
        .reset (reset),
        .rs1   (issue.rs1),
        .rs2   (issue.rs2),
        .data1 (rf_data1),
        .data2 (rf_data2),
        .we    (rf_we),
        .rd    (mem_wb.rd),
        .wdata (mem_wb.result)
    );

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex.valid     <= issue.valid;
            id_ex.pc        <= issue.pc;
            id_ex.rs1       <= issue.rs1;
            id_ex.rs2       <= issue.rs2;
            id_ex.rd        <= issue.rd;
            id_ex.imm       <= issue.imm;
            id_ex.alu_op    <= issue.alu_op;
            id_ex.alu_src   <= issue.alu_src;
            id_ex.reg_write <= issue.reg_write;
            id_ex.branch    <= issue.branch;
            // Operand reads captured with the instruction
            id_ex.data1     <= rf_data1;
            id_ex.data2     <= rf_data2;
        end
    end

    // Hazard resolution against MEM and WB
    forward_unit forward_unit_i (
        .rs1          (id_ex.rs1),
        .rs2          (id_ex.rs2),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .sel_forward1 (sel_forward1),
        .sel_forward2 (sel_forward2)
    );

    ex_stage ex_stage_i (
        .id_ex        (id_ex),
        .mem_forward  (ex_mem.result),
        .wb_forward   (mem_wb.result),
        .sel_forward1 (sel_forward1),
        .sel_forward2 (sel_forward2),
        .ex_out       (ex_out)
    );

    //////////////////////////////////////////////////
    // EX/MEM and MEM/WB registers
    //////////////////////////////////////////////////

    // No stalls, always advance
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            ex_mem <= ex_out;
            mem_wb <= ex_mem;
        end
    end

    // Retire port shows the write-back stage
    assign retire = mem_wb;

endmodule

// ==== bench/exec_pipe_checker.sv ====
`timescale 1ns/1ps

module exec_pipe_checker (
    input logic             clk,
    input logic             reset,
    input logic             issue_valid,
    input ex_pkg::stage_t   retire,
    input ex_pkg::stage_t   ex_mem,
    input ex_pkg::stage_t   mem_wb,
    input ex_pkg::fwd_sel_e sel_forward1,
    input ex_pkg::fwd_sel_e sel_forward2
);

    // Failed assertion count
    int unsigned failures = 0;

    //////////////////////////////////////////////////
    // Latency and forwarding properties
    //////////////////////////////////////////////////

    // Fixed issue to retire distance
    latency_a: assert property (@(posedge clk) disable iff (reset)
        retire.valid == $past(issue_valid, 3))
    else begin
        $error("retire valid does not follow issue valid by three cycles");
        failures++;
    end

    // MEM select never points at register zero
    mem_zero_a: assert property (@(posedge clk) disable iff (reset)
        (sel_forward1 == ex_pkg::fwd_mem || sel_forward2 == ex_pkg::fwd_mem) |->
        ex_mem.rd != '0)
    else begin
        $error("MEM forward selected for a zero destination");
        failures++;
    end

    // Same for WB
    wb_zero_a: assert property (@(posedge clk) disable iff (reset)
        (sel_forward1 == ex_pkg::fwd_wb || sel_forward2 == ex_pkg::fwd_wb) |->
        mem_wb.rd != '0)
    else begin
        $error("WB forward selected for a zero destination");
        failures++;
    end

    // Quiet retire port while held in reset
    reset_quiet_a: assert property (@(posedge clk)
        reset && $past(reset) |-> !retire.valid)
    else begin
        $error("retire valid high during reset");
        failures++;
    end

endmodule

bind exec_pipe exec_pipe_checker checker_i (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue.valid),
    .retire       (retire),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .sel_forward1 (sel_forward1),
    .sel_forward2 (sel_forward2)
);

// ==== bench/exec_pipe_tb.sv ====
`timescale 1ns/1ps

module exec_pipe_tb;

    // Issued instruction plus what must retire
    typedef struct {
        ex_pkg::issue_t ins;
        ex_pkg::stage_t exp;
        int             test;
        bit             last;
        int             idle;
    } entry_t;

    logic           clk;
    logic           reset;
    ex_pkg::issue_t issue;
    ex_pkg::stage_t retire;

    entry_t        table_q [$];
    entry_t        exp_q [$];
    ex_pkg::word_t shadow [ex_pkg::NUM_REGS];
    string         test_names [7] = '{"reset", "alu_ops", "fwd_mem", "fwd_wb",
                                      "reg_zero", "branch", "random"};
    int            test_errors [7];
    int            errors = 0;
    int            retired = 0;

    exec_pipe dut_i (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Table building
    //////////////////////////////////////////////////

    // ALU row writing rd
    function automatic void add_alu(int test, ex_pkg::alu_op_e op, ex_pkg::reg_sel_t rd,
                                    ex_pkg::reg_sel_t rs1, ex_pkg::reg_sel_t rs2,
                                    ex_pkg::word_t imm, bit src, ex_pkg::word_t result,
                                    ex_pkg::word_t wdata);
        entry_t e;
        e.ins = '0;
        e.exp = '0;
        e.ins.valid = 1'b1;
        e.ins.rs1 = rs1;
        e.ins.rs2 = rs2;
        e.ins.rd = rd;
        e.ins.imm = imm;
        e.ins.alu_op = op;
        e.ins.alu_src = src;
        e.ins.reg_write = 1'b1;
        e.exp.valid = 1'b1;
        e.exp.rd = rd;
        e.exp.reg_write = 1'b1;
        e.exp.result = result;
        e.exp.write_data = wdata;
        e.test = test;
        e.last = 1'b0;
        e.idle = 0;
        table_q.push_back(e);
    endfunction

    // Branch-if-equal row as sub with no register write
    function automatic void add_branch(int test, ex_pkg::reg_sel_t rs1, ex_pkg::reg_sel_t rs2,
                                       ex_pkg::addr_t pc, ex_pkg::word_t imm,
                                       ex_pkg::word_t result, ex_pkg::word_t wdata,
                                       bit taken, ex_pkg::addr_t target);
        entry_t e;
        e.ins = '0;
        e.exp = '0;
        e.ins.valid = 1'b1;
        e.ins.pc = pc;
        e.ins.rs1 = rs1;
        e.ins.rs2 = rs2;
        e.ins.rd = 5'd3;
        e.ins.imm = imm;
        e.ins.alu_op = ex_pkg::alu_sub;
        e.ins.branch = 1'b1;
        e.exp.valid = 1'b1;
        e.exp.rd = 5'd3;
        e.exp.result = result;
        e.exp.write_data = wdata;
        e.exp.branch = 1'b1;
        e.exp.taken = taken;
        e.exp.branch_target = target;
        e.test = test;
        e.last = 1'b0;
        e.idle = 0;
        table_q.push_back(e);
    endfunction

    // Idle cycles after the latest row
    function automatic void set_gap(int n);
        table_q[table_q.size()-1].idle = n;
    endfunction

    function automatic void end_test();
        table_q[table_q.size()-1].last = 1'b1;
    endfunction

    task automatic build_table();
        // Fresh registers read zero
        add_alu(0, ex_pkg::alu_add, 1, 2, 3, 0, 0, 0, 0);
        add_alu(0, ex_pkg::alu_or, 1, 31, 30, 0, 0, 0, 0);
        end_test();
        // x1 = -16 and x2 = 0x35
        add_alu(1, ex_pkg::alu_add, 1, 0, 0, 32'hFFFF_FFF0, 1, 32'hFFFF_FFF0, 0);
        add_alu(1, ex_pkg::alu_add, 2, 0, 0, 32'h35, 1, 32'h35, 0);
        // Register source with shift amount 21
        add_alu(1, ex_pkg::alu_add, 10, 1, 2, 0, 0, 32'h0000_0025, 32'h35);
        add_alu(1, ex_pkg::alu_sub, 10, 1, 2, 0, 0, 32'hFFFF_FFBB, 32'h35);
        add_alu(1, ex_pkg::alu_and, 10, 1, 2, 0, 0, 32'h0000_0030, 32'h35);
        add_alu(1, ex_pkg::alu_or, 10, 1, 2, 0, 0, 32'hFFFF_FFF5, 32'h35);
        add_alu(1, ex_pkg::alu_xor, 10, 1, 2, 0, 0, 32'hFFFF_FFC5, 32'h35);
        add_alu(1, ex_pkg::alu_sll, 10, 1, 2, 0, 0, 32'hFE00_0000, 32'h35);
        add_alu(1, ex_pkg::alu_srl, 10, 1, 2, 0, 0, 32'h0000_07FF, 32'h35);
        add_alu(1, ex_pkg::alu_sra, 10, 1, 2, 0, 0, 32'hFFFF_FFFF, 32'h35);
        add_alu(1, ex_pkg::alu_slt, 10, 1, 2, 0, 0, 32'h1, 32'h35);
        add_alu(1, ex_pkg::alu_sltu, 10, 1, 2, 0, 0, 32'h0, 32'h35);
        // Immediate source
        add_alu(1, ex_pkg::alu_add, 10, 1, 0, 32'h100, 1, 32'h0000_00F0, 0);
        add_alu(1, ex_pkg::alu_sub, 10, 1, 0, 32'h10, 1, 32'hFFFF_FFE0, 0);
        add_alu(1, ex_pkg::alu_and, 10, 1, 0, 32'h0000_FF0F, 1, 32'h0000_FF00, 0);
        add_alu(1, ex_pkg::alu_or, 10, 1, 0, 32'hF, 1, 32'hFFFF_FFFF, 0);
        add_alu(1, ex_pkg::alu_xor, 10, 1, 0, 32'hFFFF_FFFF, 1, 32'h0000_000F, 0);
        add_alu(1, ex_pkg::alu_sll, 10, 1, 0, 32'h4, 1, 32'hFFFF_FF00, 0);
        add_alu(1, ex_pkg::alu_srl, 10, 1, 0, 32'h1C, 1, 32'h0000_000F, 0);
        // Only the low five bits shift
        add_alu(1, ex_pkg::alu_sra, 10, 1, 0, 32'h24, 1, 32'hFFFF_FFFF, 0);
        add_alu(1, ex_pkg::alu_slt, 10, 1, 0, 32'hFFFF_FFF1, 1, 32'h1, 0);
        add_alu(1, ex_pkg::alu_sltu, 10, 1, 0, 32'h5, 1, 32'h0, 0);
        end_test();
        // Consumers right behind producers on rs1 then rs2 then both
        add_alu(2, ex_pkg::alu_add, 3, 0, 0, 32'h111, 1, 32'h111, 0);
        add_alu(2, ex_pkg::alu_add, 4, 3, 0, 0, 0, 32'h111, 0);
        add_alu(2, ex_pkg::alu_add, 5, 0, 0, 32'h222, 1, 32'h222, 0);
        add_alu(2, ex_pkg::alu_add, 6, 0, 5, 0, 0, 32'h222, 32'h222);
        add_alu(2, ex_pkg::alu_add, 7, 0, 0, 32'h333, 1, 32'h333, 0);
        add_alu(2, ex_pkg::alu_add, 8, 7, 7, 0, 0, 32'h666, 32'h333);
        end_test();
        // Distance two and then distance three through the bypass
        add_alu(3, ex_pkg::alu_add, 9, 0, 0, 32'h1000, 1, 32'h1000, 0);
        set_gap(1);
        add_alu(3, ex_pkg::alu_add, 12, 9, 9, 32'h1, 1, 32'h1001, 32'h1000);
        set_gap(2);
        add_alu(3, ex_pkg::alu_add, 13, 12, 12, 0, 0, 32'h2002, 32'h1001);
        // x14 in both MEM and WB where the younger wins
        add_alu(3, ex_pkg::alu_add, 14, 0, 0, 32'hA, 1, 32'hA, 0);
        add_alu(3, ex_pkg::alu_add, 14, 0, 0, 32'hB, 1, 32'hB, 0);
        add_alu(3, ex_pkg::alu_add, 15, 14, 14, 0, 0, 32'h16, 32'hB);
        end_test();
        // Result still shows on retire while x0 stays zero
        add_alu(4, ex_pkg::alu_add, 0, 0, 0, 32'h55, 1, 32'h55, 0);
        add_alu(4, ex_pkg::alu_add, 16, 0, 0, 0, 0, 0, 0);
        add_alu(4, ex_pkg::alu_add, 17, 0, 0, 32'h7, 1, 32'h7, 0);
        set_gap(3);
        add_alu(4, ex_pkg::alu_or, 18, 0, 0, 0, 0, 0, 0);
        end_test();
        // Equal, unequal with negative offset, target wrap
        add_branch(5, 3, 4, 10'h010, 32'h4, 32'h0, 32'h111, 1, 10'h020);
        add_branch(5, 3, 5, 10'h100, 32'hFFFF_FFFE, 32'hFFFF_FEEF, 32'h222, 0, 10'h0F8);
        add_branch(5, 5, 6, 10'h3F0, 32'h10, 32'h0, 32'h222, 1, 10'h030);
        // x3 untouched by the branches
        add_alu(5, ex_pkg::alu_add, 21, 3, 0, 0, 0, 32'h111, 0);
        end_test();
    endtask

    //////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////

    task automatic issue_entry(input entry_t e);
        @(posedge clk);
        issue <= e.ins;
        exp_q.push_back(e);
        if (e.exp.reg_write && e.exp.rd != '0) begin
            shadow[e.exp.rd] = e.exp.result;
        end
        repeat (e.idle) begin
            @(posedge clk);
            issue <= '0;
        end
    endtask

    task automatic compare_field(input int test, input string name,
                                 input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("Fail at %0d ns: retire.%s got %h expected %h", $time, name, got, want);
            errors++;
            test_errors[test]++;
        end
    endtask

    // Retire sampled mid-cycle away from the edge
    always @(negedge clk) begin
        entry_t e;
        if (retire.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("At %0d ns an instruction retired that was never issued", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                retired++;
                compare_field(e.test, "rd", 32'(retire.rd), 32'(e.exp.rd));
                compare_field(e.test, "reg_write", 32'(retire.reg_write), 32'(e.exp.reg_write));
                compare_field(e.test, "result", retire.result, e.exp.result);
                compare_field(e.test, "write_data", retire.write_data, e.exp.write_data);
                compare_field(e.test, "branch", 32'(retire.branch), 32'(e.exp.branch));
                compare_field(e.test, "taken", 32'(retire.taken), 32'(e.exp.taken));
                // Target only meaningful on branches
                if (e.exp.branch) begin
                    compare_field(e.test, "branch_target", 32'(retire.branch_target),
                                  32'(e.exp.branch_target));
                end
                if (e.last) begin
                    $display("test %-8s %s, %0d errors", test_names[e.test],
                             test_errors[e.test] == 0 ? "passed" : "failed",
                             test_errors[e.test]);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        entry_t        e;
        ex_pkg::word_t arg2;
        reset = 1'b1;
        issue = '0;
        void'($urandom(32'h12ee32ac));
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            issue_entry(table_q[i]);
        end
        // 40 random add/xor predicted from the shadow registers
        for (int i = 0; i < 40; i++) begin
            e.ins = '0;
            e.exp = '0;
            e.ins.valid = 1'b1;
            e.ins.rs1 = ex_pkg::reg_sel_t'($urandom());
            e.ins.rs2 = ex_pkg::reg_sel_t'($urandom());
            e.ins.rd = ex_pkg::reg_sel_t'($urandom());
            e.ins.imm = $urandom();
            e.ins.alu_src = 1'($urandom());
            e.ins.alu_op = ($urandom() % 2 == 0) ? ex_pkg::alu_add : ex_pkg::alu_xor;
            e.ins.reg_write = 1'b1;
            arg2 = e.ins.alu_src ? e.ins.imm : shadow[e.ins.rs2];
            e.exp.valid = 1'b1;
            e.exp.rd = e.ins.rd;
            e.exp.reg_write = 1'b1;
            e.exp.write_data = shadow[e.ins.rs2];
            if (e.ins.alu_op == ex_pkg::alu_add) begin
                e.exp.result = shadow[e.ins.rs1] + arg2;
            end else begin
                e.exp.result = shadow[e.ins.rs1] ^ arg2;
            end
            e.test = 6;
            e.last = (i == 39);
            e.idle = 0;
            issue_entry(e);
        end
        @(posedge clk);
        issue <= '0;
        // Drain the pipeline
        for (int i = 0; i < 10 && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d issued instructions never retired", exp_q.size());
            errors++;
        end
        assert (dut_i.checker_i.failures == 0) else begin
            $display("Bound checker saw %0d assertion failures", dut_i.checker_i.failures);
            errors += dut_i.checker_i.failures;
        end
        $display("%0d of %0d instructions retired, %0d errors", retired,
                 table_q.size() + 40, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog allows one cycle per issue plus margin
    initial begin
        @(negedge reset);
        #((table_q.size() + 40 + 20) * 10);
        $display("Watchdog expired at %0d ns with %0d instructions outstanding",
                 $time, exp_q.size());
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== exec_pipe.f ====
common/ex_pkg.sv
design/reg_file.sv
design/forward_unit.sv
ex_stage/alu.sv
ex_stage/ex_stage.sv
design/exec_pipe.sv
bench/exec_pipe_checker.sv
bench/exec_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute pipeline testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail on a reported failure"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_pipe_tb \
		-f exec_pipe.f -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
